// File: include/rv32_opcodes.svh
`ifndef RV32_OPCODES_SVH
`define RV32_OPCODES_SVH

// major opcodes of the supported subset.
`define OP_LUI    7'b0110111
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111

// funct3 values.
`define F3_ADD 3'b000
`define F3_XOR 3'b100
`define F3_OR  3'b110
`define F3_AND 3'b111
`define F3_BEQ 3'b000
`define F3_BNE 3'b001
`define F3_LW  3'b010
`define F3_SW  3'b010

// funct7 values for the register ops.
`define F7_BASE 7'b0000000
`define F7_SUB  7'b0100000

`endif

// File: hdl/rv32_pkg.sv
package rv32_pkg;

    localparam int xlen = 32;

    // unified memory, word addressed.
    localparam int mem_words = 1024;
    localparam int mem_addr_bits = $clog2(mem_words);

    localparam logic [xlen-1:0] reset_pc = '0;
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013; // addi x0, x0, 0.

    typedef logic [4:0] reg_addr_t;

    localparam reg_addr_t led_reg = 5'd31; // writes here drive the leds.

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b // lui.
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none,
        br_eq,
        br_ne,
        br_jump
    } branch_op_e;

endpackage

// File: hdl/rv32_fetch.sv
`timescale 1ns/1ps

module rv32_fetch import rv32_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            flush,
    input  logic            branch_taken,
    input  logic [xlen-1:0] branch_pc,
    input  logic            if_gnt,
    input  logic [xlen-1:0] if_rdata,
    output logic            if_req,
    output logic [xlen-1:0] if_addr,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] instr
);
    logic [xlen-1:0] fetch_pc;
    logic            req_en;

    assign if_req  = req_en;
    assign if_addr = fetch_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_en   <= 1'b0;
            fetch_pc <= reset_pc;
        end else begin
            req_en <= 1'b1;
            if (branch_taken)
                fetch_pc <= branch_pc; // redirect beats everything.
            else if (if_gnt && !stall)
                fetch_pc <= fetch_pc + 32'd4;
        end
    end

    // fetch/decode register, a nop stands in for a bubble.
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            instr <= nop_instr;
        end else if (!stall) begin
            pc    <= fetch_pc;
            instr <= if_gnt ? if_rdata : nop_instr;
        end
    end

endmodule

// File: hdl/rv32_decode.sv
`timescale 1ns/1ps
`include "rv32_opcodes.svh"

module rv32_decode import rv32_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            flush,
    input  logic [xlen-1:0] if_pc,
    input  logic [xlen-1:0] if_instr,
    input  reg_addr_t       wb_rd,
    input  logic            wb_en,
    input  logic [xlen-1:0] wb_value,
    output reg_addr_t       rs1,
    output reg_addr_t       rs2,
    output alu_op_e         alu_op,
    output logic            alu_src2_imm,
    output logic            mem_read_en,
    output logic            mem_write_en,
    output branch_op_e      branch_op,
    output reg_addr_t       rd,
    output logic            rd_writeback,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] rs1_value,
    output logic [xlen-1:0] rs2_value,
    output logic [xlen-1:0] imm
);
    logic [xlen-1:0] regs [1:31]; // x0 is not stored.

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    reg_addr_t       src1, src2, dst;
    alu_op_e         d_alu_op;
    branch_op_e      d_branch_op;
    logic            d_src2_imm, d_wb, d_read, d_write, use_rs1, use_rs2;
    logic [xlen-1:0] d_imm, rf_rs1, rf_rs2;

    assign opcode = if_instr[6:0];
    assign funct3 = if_instr[14:12];
    assign funct7 = if_instr[31:25];
    assign dst    = if_instr[11:7];
    assign src1   = use_rs1 ? if_instr[19:15] : '0; // unused sources read as x0.
    assign src2   = use_rs2 ? if_instr[24:20] : '0;

    always_comb begin
        d_alu_op    = alu_add;
        d_branch_op = br_none;
        d_src2_imm  = 1'b0;
        d_wb        = 1'b0;
        d_read      = 1'b0;
        d_write     = 1'b0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        d_imm       = {{20{if_instr[31]}}, if_instr[31:20]}; // i-type.
        case (opcode)
            `OP_LUI: begin
                d_alu_op   = alu_pass_b;
                d_src2_imm = 1'b1;
                d_wb       = 1'b1;
                d_imm      = {if_instr[31:12], 12'b0};
            end
            `OP_IMM, `OP_REG: begin
                use_rs1    = 1'b1;
                use_rs2    = (opcode == `OP_REG);
                d_src2_imm = (opcode == `OP_IMM);
                d_wb       = 1'b1;
                case (funct3)
                    `F3_ADD: d_alu_op = (use_rs2 && funct7 == `F7_SUB) ? alu_sub : alu_add;
                    `F3_XOR: d_alu_op = alu_xor;
                    `F3_OR:  d_alu_op = alu_or;
                    `F3_AND: d_alu_op = alu_and;
                    default: d_wb = 1'b0; // unsupported funct3 becomes a nop.
                endcase
            end
            `OP_LOAD: begin
                use_rs1    = 1'b1;
                d_src2_imm = 1'b1;
                d_read     = (funct3 == `F3_LW);
                d_wb       = (funct3 == `F3_LW);
            end
            `OP_STORE: begin
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
                d_src2_imm = 1'b1;
                d_write    = (funct3 == `F3_SW);
                d_imm      = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            end
            `OP_BRANCH: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                d_branch_op = (funct3 == `F3_BEQ) ? br_eq :
                              (funct3 == `F3_BNE) ? br_ne : br_none;
                d_imm       = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                               if_instr[30:25], if_instr[11:8], 1'b0};
            end
            `OP_JAL: begin
                d_branch_op = br_jump;
                d_wb        = 1'b1;
                d_imm       = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                               if_instr[20], if_instr[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    // register file read with same-cycle writeback bypass.
    always_comb begin
        rf_rs1 = (wb_en && wb_rd == src1) ? wb_value : regs[src1];
        rf_rs2 = (wb_en && wb_rd == src2) ? wb_value : regs[src2];
        if (src1 == '0) rf_rs1 = '0;
        if (src2 == '0) rf_rs2 = '0;
    end

    always_ff @(posedge clk) begin
        if (wb_en)
            regs[wb_rd] <= wb_value; // wb_en never comes with x0.
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_writeback <= 1'b0;
            mem_read_en  <= 1'b0;
            mem_write_en <= 1'b0;
            branch_op    <= br_none;
        end else if (!stall) begin
            rd_writeback <= d_wb && (dst != '0);
            mem_read_en  <= d_read;
            mem_write_en <= d_write;
            branch_op    <= d_branch_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rs1          <= src1;
            rs2          <= src2;
            alu_op       <= d_alu_op;
            alu_src2_imm <= d_src2_imm;
            rd           <= dst;
            pc           <= if_pc;
            rs1_value    <= rf_rs1;
            rs2_value    <= rf_rs2;
            imm          <= d_imm;
        end else begin
            // a held instruction must not miss a write that retires under it.
            if (wb_en && wb_rd == rs1)
                rs1_value <= wb_value;
            if (wb_en && wb_rd == rs2)
                rs2_value <= wb_value;
        end
    end

endmodule

// File: hdl/rv32_execute.sv
`timescale 1ns/1ps

module rv32_execute import rv32_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            flush,
    input  reg_addr_t       id_rs1,
    input  reg_addr_t       id_rs2,
    input  alu_op_e         id_alu_op,
    input  logic            id_alu_src2_imm,
    input  logic            id_mem_read_en,
    input  logic            id_mem_write_en,
    input  branch_op_e      id_branch_op,
    input  reg_addr_t       id_rd,
    input  logic            id_rd_writeback,
    input  logic [xlen-1:0] id_pc,
    input  logic [xlen-1:0] id_rs1_value,
    input  logic [xlen-1:0] id_rs2_value,
    input  logic [xlen-1:0] id_imm,
    input  reg_addr_t       ex_fwd_rd,
    input  logic            ex_fwd_en,
    input  logic [xlen-1:0] ex_fwd_value,
    input  reg_addr_t       wb_rd,
    input  logic            wb_en,
    input  logic [xlen-1:0] wb_value,
    output logic            mem_read_en,
    output logic            mem_write_en,
    output branch_op_e      branch_op,
    output reg_addr_t       rd,
    output logic            rd_writeback,
    output logic [xlen-1:0] result,
    output logic [xlen-1:0] rs2_value,
    output logic [xlen-1:0] branch_pc,
    output logic            zero
);
    logic [xlen-1:0] op1, op2, src2, alu_out;

    always_comb begin
        // memory stage is newer than writeback, so it is checked first.
        op1 = id_rs1_value;
        if (ex_fwd_en && ex_fwd_rd == id_rs1)
            op1 = ex_fwd_value;
        else if (wb_en && wb_rd == id_rs1)
            op1 = wb_value;
        op2 = id_rs2_value;
        if (ex_fwd_en && ex_fwd_rd == id_rs2)
            op2 = ex_fwd_value;
        else if (wb_en && wb_rd == id_rs2)
            op2 = wb_value;
        src2 = id_alu_src2_imm ? id_imm : op2;
        case (id_alu_op)
            alu_sub:    alu_out = op1 - src2;
            alu_and:    alu_out = op1 & src2;
            alu_or:     alu_out = op1 | src2;
            alu_xor:    alu_out = op1 ^ src2;
            alu_pass_b: alu_out = src2;
            default:    alu_out = op1 + src2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            mem_read_en  <= 1'b0;
            mem_write_en <= 1'b0;
            branch_op    <= br_none;
            rd_writeback <= 1'b0;
        end else if (!stall) begin
            mem_read_en  <= id_mem_read_en;
            mem_write_en <= id_mem_write_en;
            branch_op    <= id_branch_op;
            rd_writeback <= id_rd_writeback;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rd        <= id_rd;
            result    <= (id_branch_op == br_jump) ? id_pc + 32'd4 : alu_out; // link value.
            rs2_value <= op2; // store data.
            branch_pc <= id_pc + id_imm;
            zero      <= (op1 == op2);
        end
    end

endmodule

// File: hdl/rv32_mem.sv
`timescale 1ns/1ps

module rv32_mem import rv32_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            flush,
    input  logic            ex_mem_read_en,
    input  logic            ex_mem_write_en,
    input  branch_op_e      ex_branch_op,
    input  reg_addr_t       ex_rd,
    input  logic            ex_rd_writeback,
    input  logic [xlen-1:0] ex_result,
    input  logic [xlen-1:0] ex_rs2_value,
    input  logic [xlen-1:0] ex_branch_pc,
    input  logic            ex_zero,
    input  logic [xlen-1:0] d_rdata,
    output logic            d_req,
    output logic            d_we,
    output logic [xlen-1:0] d_addr,
    output logic [xlen-1:0] d_wdata,
    output logic            branch_taken,
    output logic [xlen-1:0] branch_pc,
    output reg_addr_t       rd,
    output logic            rd_writeback,
    output logic [xlen-1:0] rd_value
);
    // word accesses only, the data port is served in this cycle.
    assign d_req     = ex_mem_read_en | ex_mem_write_en;
    assign d_we      = ex_mem_write_en;
    assign d_addr    = ex_result;
    assign d_wdata   = ex_rs2_value;
    assign branch_pc = ex_branch_pc;

    always_comb begin
        case (ex_branch_op)
            br_eq:   branch_taken = ex_zero;
            br_ne:   branch_taken = !ex_zero;
            br_jump: branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush)
            rd_writeback <= 1'b0;
        else if (!stall)
            rd_writeback <= ex_rd_writeback;
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rd       <= ex_rd;
            rd_value <= ex_mem_read_en ? d_rdata : ex_result;
        end
    end

endmodule

// File: hdl/rv32_hazard.sv
`timescale 1ns/1ps

module rv32_hazard import rv32_pkg::*; (
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  logic      ex_mem_read,
    input  reg_addr_t ex_rd,
    input  logic      branch_taken,
    input  logic      if_gnt,
    output logic      fetch_stall,
    output logic      fetch_flush,
    output logic      decode_stall,
    output logic      decode_flush,
    output logic      execute_flush,
    output logic      mem_flush
);
    logic load_use;

    // load in the memory stage feeding the instruction in execute.
    assign load_use = ex_mem_read && (ex_rd != '0) && (ex_rd == rs1 || ex_rd == rs2);

    // a lost grant leaves a bubble behind fetch, unless load-use holds it.
    assign fetch_flush   = branch_taken || (!if_gnt && !load_use);
    assign fetch_stall   = (load_use || !if_gnt) && !fetch_flush;
    assign decode_flush  = branch_taken;
    assign decode_stall  = load_use && !decode_flush;
    assign execute_flush = branch_taken || load_use;
    assign mem_flush     = 1'b0; // a taken branch still retires.

endmodule

// File: hdl/rv32_mem_arbiter.sv
`timescale 1ns/1ps

module rv32_mem_arbiter import rv32_pkg::*; (
    input  logic            clk,
    input  logic            if_req,
    input  logic [xlen-1:0] if_addr,
    output logic            if_gnt,
    output logic [xlen-1:0] if_rdata,
    input  logic            d_req,
    input  logic            d_we,
    input  logic [xlen-1:0] d_addr,
    input  logic [xlen-1:0] d_wdata,
    output logic [xlen-1:0] d_rdata
);
    logic [xlen-1:0]          mem [mem_words];
    logic [mem_addr_bits-1:0] index;
    logic [xlen-1:0]          rdata;

    assign if_gnt = if_req && !d_req; // data port has priority.

    // one address into the array, byte address dropped to a word index.
    assign index = d_req ? d_addr[mem_addr_bits+1:2] : if_addr[mem_addr_bits+1:2];
    assign rdata = mem[index];

    assign if_rdata = rdata;
    assign d_rdata  = rdata;

    always_ff @(posedge clk) begin
        if (d_req && d_we)
            mem[index] <= d_wdata;
    end

endmodule

// File: hdl/rv32.sv
`timescale 1ns/1ps

module rv32 import rv32_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    output logic [7:0] leds,
    output logic       leds_strobe
);
    logic fetch_stall, fetch_flush, decode_stall, decode_flush, execute_flush, mem_flush;

    // memory ports.
    logic            if_req, if_gnt, d_req, d_we;
    logic [xlen-1:0] if_addr, if_rdata, d_addr, d_wdata, d_rdata;

    logic [xlen-1:0] if_pc, if_instr;

    logic [xlen-1:0] id_pc, id_rs1_value, id_rs2_value, id_imm;
    reg_addr_t       id_rs1, id_rs2, id_rd;
    alu_op_e         id_alu_op;
    branch_op_e      id_branch_op;
    logic            id_alu_src2_imm, id_mem_read_en, id_mem_write_en, id_rd_writeback;

    logic            ex_mem_read_en, ex_mem_write_en, ex_rd_writeback, ex_zero;
    branch_op_e      ex_branch_op;
    reg_addr_t       ex_rd;
    logic [xlen-1:0] ex_result, ex_rs2_value, ex_branch_pc;

    logic            mem_branch_taken;
    logic [xlen-1:0] mem_branch_pc;

    // writeback bus.
    reg_addr_t       wb_rd;
    logic            wb_en;
    logic [xlen-1:0] wb_value;

    always_ff @(posedge clk) begin
        if (rst) begin
            leds        <= '0;
            leds_strobe <= 1'b0;
        end else begin
            leds_strobe <= wb_en && (wb_rd == led_reg);
            if (wb_en && wb_rd == led_reg)
                leds <= wb_value[7:0];
        end
    end

    rv32_hazard i_hazard (
        .rs1(id_rs1), .rs2(id_rs2), .ex_mem_read(ex_mem_read_en), .ex_rd,
        .branch_taken(mem_branch_taken), .if_gnt,
        .fetch_stall, .fetch_flush, .decode_stall, .decode_flush, .execute_flush, .mem_flush
    );

    rv32_mem_arbiter i_arbiter (
        .clk, .if_req, .if_addr, .if_gnt, .if_rdata, .d_req, .d_we, .d_addr, .d_wdata, .d_rdata
    );

    rv32_fetch i_fetch (
        .clk, .rst, .stall(fetch_stall), .flush(fetch_flush),
        .branch_taken(mem_branch_taken), .branch_pc(mem_branch_pc),
        .if_gnt, .if_rdata, .if_req, .if_addr, .pc(if_pc), .instr(if_instr)
    );

    rv32_decode i_decode (
        .clk, .rst, .stall(decode_stall), .flush(decode_flush),
        .if_pc, .if_instr, .wb_rd, .wb_en, .wb_value,
        .rs1(id_rs1), .rs2(id_rs2), .alu_op(id_alu_op), .alu_src2_imm(id_alu_src2_imm),
        .mem_read_en(id_mem_read_en), .mem_write_en(id_mem_write_en),
        .branch_op(id_branch_op), .rd(id_rd), .rd_writeback(id_rd_writeback),
        .pc(id_pc), .rs1_value(id_rs1_value), .rs2_value(id_rs2_value), .imm(id_imm)
    );

    // execute and memory never stall, the data port always wins.
    rv32_execute i_execute (
        .clk, .rst, .stall(1'b0), .flush(execute_flush),
        .id_rs1, .id_rs2, .id_alu_op, .id_alu_src2_imm, .id_mem_read_en, .id_mem_write_en,
        .id_branch_op, .id_rd, .id_rd_writeback, .id_pc, .id_rs1_value, .id_rs2_value,
        .id_imm,
        .ex_fwd_rd(ex_rd), .ex_fwd_en(ex_rd_writeback), .ex_fwd_value(ex_result),
        .wb_rd, .wb_en, .wb_value,
        .mem_read_en(ex_mem_read_en), .mem_write_en(ex_mem_write_en),
        .branch_op(ex_branch_op), .rd(ex_rd), .rd_writeback(ex_rd_writeback),
        .result(ex_result), .rs2_value(ex_rs2_value), .branch_pc(ex_branch_pc),
        .zero(ex_zero)
    );

    rv32_mem i_mem (
        .clk, .rst, .stall(1'b0), .flush(mem_flush),
        .ex_mem_read_en, .ex_mem_write_en, .ex_branch_op, .ex_rd, .ex_rd_writeback,
        .ex_result, .ex_rs2_value, .ex_branch_pc, .ex_zero,
        .d_rdata, .d_req, .d_we, .d_addr, .d_wdata,
        .branch_taken(mem_branch_taken), .branch_pc(mem_branch_pc),
        .rd(wb_rd), .rd_writeback(wb_en), .rd_value(wb_value)
    );

endmodule

// File: tb/rv32_checker.sv
`timescale 1ns/1ps

module rv32_checker import rv32_pkg::*; (
    input logic            clk,
    input logic            rst,
    input logic            if_req,
    input logic            if_gnt,
    input logic [xlen-1:0] if_addr,
    input logic [xlen-1:0] if_instr,
    input logic            d_req,
    input logic            mem_branch_taken,
    input logic            fetch_stall,
    input logic            decode_stall,
    input logic            leds_strobe
);
    // fetch hands decode a nop while the data port has the memory.
    a_bubble: assert property (@(posedge clk) disable iff (rst)
        d_req && !fetch_stall |=> if_instr == nop_instr)
        else $error("data access did not leave a bubble behind fetch");

    // an ungranted fetch keeps asking for the same word.
    a_hold: assert property (@(posedge clk) disable iff (rst)
        if_req && !if_gnt && !mem_branch_taken |=> if_req && $stable(if_addr))
        else $error("fetch moved on without a grant");

    a_load_use: assert property (@(posedge clk) disable iff (rst)
        decode_stall |=> !decode_stall)
        else $error("load-use stall longer than one cycle");

    a_pulse: assert property (@(posedge clk) disable iff (rst) leds_strobe |=> !leds_strobe)
        else $error("leds strobe longer than one cycle");

    a_reset: assert property (@(posedge clk) rst |=> !leds_strobe)
        else $error("leds strobe high after reset");

endmodule

bind rv32 rv32_checker i_checker (.*);

// File: tb/rv32_tb.sv
`timescale 1ns/1ps
`include "rv32_opcodes.svh"

module rv32_tb import rv32_pkg::*; ();
    logic       clk;
    logic       rst;
    logic [7:0] leds;
    logic       leds_strobe;

    logic [31:0] code [$];      // all programs back to back.
    int          start [5];
    int          len [5];
    string       names [5] = '{"alu", "forward", "load_store", "branch", "reset_x0"};
    int          cur;
    logic [31:0] lfsr_state = 32'd81;
    logic [7:0]  expected [$];
    string       test_name;
    int          errors;
    int          checks;
    int          total_cycles;

    rv32 i_dut (.clk, .rst, .leds, .leds_strobe);

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state); // one step per bit.
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [11:0] rand_imm12();
        logic [31:0] v;
        v = rand_bits(12);
        return v[11:0];
    endfunction

    function automatic logic [19:0] rand_imm20();
        logic [31:0] v;
        v = rand_bits(20);
        return v[19:0];
    endfunction

    // instruction formats.
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return i_type(`OP_IMM, `F3_ADD, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, `F3_SW, imm[4:0], `OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, `OP_LUI};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
    endfunction

    task automatic emit(input logic [31:0] w);
        code.push_back(w);
        len[cur]++;
    endtask

    task automatic begin_program(input int t);
        cur      = t;
        start[t] = code.size();
        len[t]   = 0;
    endtask

    task automatic build_programs();
        begin_program(0);
        for (int k = 0; k < 5; k++) begin
            emit(lui_word(5'd1, rand_imm20()));
            emit(addi(5'd1, 5'd1, rand_imm12()));
            emit(addi(5'd2, 5'd0, rand_imm12()));
            case (k)
                0: emit(r_type(`F7_BASE, 5'd2, 5'd1, `F3_ADD, 5'd3));
                1: emit(r_type(`F7_SUB, 5'd2, 5'd1, `F3_ADD, 5'd3));
                2: emit(r_type(`F7_BASE, 5'd2, 5'd1, `F3_AND, 5'd3));
                3: emit(r_type(`F7_BASE, 5'd2, 5'd1, `F3_OR, 5'd3));
                default: emit(r_type(`F7_BASE, 5'd2, 5'd1, `F3_XOR, 5'd3));
            endcase
            emit(addi(5'd31, 5'd3, 12'd0));
        end
        emit(addi(5'd4, 5'd0, 12'd1));
        emit(lui_word(5'd31, rand_imm20()));
        emit(jal_word(5'd0, 21'd0)); // park.
        begin_program(1);
        emit(addi(5'd5, 5'd0, rand_imm12()));
        emit(addi(5'd6, 5'd5, rand_imm12()));                // distance 1.
        emit(addi(5'd7, 5'd0, rand_imm12()));
        emit(r_type(`F7_BASE, 5'd7, 5'd6, `F3_ADD, 5'd8));   // distances 2 and 1.
        emit(addi(5'd9, 5'd0, rand_imm12()));
        emit(addi(5'd10, 5'd0, rand_imm12()));
        emit(r_type(`F7_SUB, 5'd9, 5'd8, `F3_ADD, 5'd31));   // distances 3 and 2.
        emit(addi(5'd4, 5'd0, 12'd1));
        emit(r_type(`F7_BASE, 5'd10, 5'd31, `F3_XOR, 5'd31));
        emit(addi(5'd5, 5'd5, rand_imm12()));
        emit(addi(5'd4, 5'd0, 12'd0));
        emit(addi(5'd4, 5'd0, 12'd0));
        emit(addi(5'd31, 5'd5, 12'd0));                      // distance 3.
        emit(jal_word(5'd0, 21'd0));
        begin_program(2);
        emit(addi(5'd1, 5'd0, 12'd1024));
        emit(lui_word(5'd2, rand_imm20()));
        emit(addi(5'd2, 5'd2, rand_imm12()));
        emit(s_type(5'd2, 5'd1, 12'd0));
        emit(addi(5'd3, 5'd0, rand_imm12()));
        emit(s_type(5'd3, 5'd1, 12'd4));
        emit(i_type(`OP_LOAD, `F3_LW, 5'd4, 5'd1, 12'd0));
        emit(addi(5'd31, 5'd4, 12'd0));                      // load-use.
        emit(i_type(`OP_LOAD, `F3_LW, 5'd5, 5'd1, 12'd4));
        emit(r_type(`F7_BASE, 5'd4, 5'd5, `F3_ADD, 5'd31));
        emit(s_type(5'd31, 5'd1, 12'd8));
        emit(i_type(`OP_LOAD, `F3_LW, 5'd31, 5'd1, 12'd8));
        emit(i_type(`OP_LOAD, `F3_LW, 5'd6, 5'd1, 12'd8));
        emit(r_type(`F7_SUB, 5'd6, 5'd2, `F3_ADD, 5'd7));    // load-use on rs2.
        emit(addi(5'd31, 5'd7, 12'd0));
        emit(jal_word(5'd0, 21'd0));
        begin_program(3);
        emit(addi(5'd1, 5'd0, 12'd5));
        emit(addi(5'd2, 5'd0, 12'd5));
        emit(addi(5'd3, 5'd0, 12'd7));
        emit(addi(5'd31, 5'd0, 12'd1));
        emit(b_type(`F3_BEQ, 5'd1, 5'd2, 13'd8));            // taken.
        emit(addi(5'd31, 5'd0, 12'd2));
        emit(addi(5'd31, 5'd0, 12'd3));
        emit(b_type(`F3_BNE, 5'd1, 5'd2, 13'd8));            // not taken.
        emit(addi(5'd31, 5'd0, 12'd4));
        emit(b_type(`F3_BEQ, 5'd1, 5'd3, 13'd8));            // not taken.
        emit(addi(5'd31, 5'd0, 12'd5));
        emit(b_type(`F3_BNE, 5'd1, 5'd3, 13'd8));            // taken.
        emit(addi(5'd31, 5'd0, 12'd6));
        emit(jal_word(5'd9, 21'd12));
        emit(addi(5'd31, 5'd0, 12'd7));
        emit(addi(5'd31, 5'd0, 12'd8));
        emit(addi(5'd31, 5'd9, 12'd0));                      // link value.
        emit(jal_word(5'd0, 21'd0));
        begin_program(4);
        emit(addi(5'd0, 5'd0, 12'd99));
        emit(r_type(`F7_BASE, 5'd0, 5'd0, `F3_ADD, 5'd31));
        emit(lui_word(5'd0, 20'h12345));
        emit(addi(5'd31, 5'd0, 12'd3));
        emit(addi(5'd1, 5'd0, 12'd9));
        emit(r_type(`F7_BASE, 5'd1, 5'd1, `F3_ADD, 5'd0));
        emit(r_type(`F7_BASE, 5'd1, 5'd0, `F3_ADD, 5'd31));
        emit(jal_word(5'd0, 21'd0));
    endtask

    function automatic logic [31:0] fill_word(input int a);
        logic [31:0] w;
        w = a;
        return {w[15:0] ^ 16'h5a5a, w[15:0]};
    endfunction

    function automatic logic [31:0] image_word(input int t, input int a);
        if (a < len[t])
            return code[start[t] + a];
        return fill_word(a);
    endfunction

    // architectural model of the subset, pushes every x31 write.
    function automatic void run_model(input int t);
        logic [31:0] x [32];
        logic [31:0] m [mem_words];
        logic [31:0] pc, next, ins, a, b, src2, res, addr;
        logic [31:0] imm_i, imm_s, imm_b, imm_j;
        logic        wr;
        for (int i = 0; i < mem_words; i++)
            m[i] = image_word(t, i);
        for (int i = 0; i < 32; i++)
            x[i] = '0;
        pc = reset_pc;
        for (int step = 0; step < 4096; step++) begin
            ins = m[pc[mem_addr_bits+1:2]];
            if (ins == jal_word(5'd0, 21'd0))
                break;
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            res   = '0;
            wr    = 1'b0;
            next  = pc + 32'd4;
            case (ins[6:0])
                `OP_LUI: begin
                    res = {ins[31:12], 12'b0};
                    wr  = 1'b1;
                end
                `OP_IMM, `OP_REG: begin
                    src2 = (ins[6:0] == `OP_IMM) ? imm_i : b;
                    wr   = 1'b1;
                    case (ins[14:12])
                        `F3_ADD: res = (ins[6:0] == `OP_REG && ins[31:25] == `F7_SUB) ?
                                       a - src2 : a + src2;
                        `F3_XOR: res = a ^ src2;
                        `F3_OR:  res = a | src2;
                        default: res = a & src2;
                    endcase
                end
                `OP_LOAD: begin
                    addr = a + imm_i;
                    res  = m[addr[mem_addr_bits+1:2]];
                    wr   = 1'b1;
                end
                `OP_STORE: begin
                    addr = a + imm_s;
                    m[addr[mem_addr_bits+1:2]] = b;
                end
                `OP_BRANCH: begin
                    if ((a == b) ^ (ins[14:12] == `F3_BNE))
                        next = pc + imm_b;
                end
                default: begin // jal.
                    res  = pc + 32'd4;
                    wr   = 1'b1;
                    next = pc + imm_j;
                end
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                x[ins[11:7]] = res;
                if (ins[11:7] == led_reg)
                    expected.push_back(res[7:0]);
            end
            pc = next;
        end
    endfunction

    task automatic check_leds(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch in %s: expected 0x%02h, actual 0x%02h", name, exp, act);
            errors++;
        end
    endtask

    // one expected value is consumed per strobe.
    always @(negedge clk) begin
        if (!rst && leds_strobe) begin
            if (expected.size() == 0) begin
                $display("Error: test %s wrote x31 more often than expected", test_name);
                errors++;
            end else begin
                check_leds(test_name, expected.pop_front(), leds);
            end
        end
    end

    task automatic run_test(input int t);
        int c;
        test_name = names[t];
        @(posedge clk);
        #1 rst = 1'b1;
        for (int a = 0; a < mem_words; a++)
            i_dut.i_arbiter.mem[a] = image_word(t, a);
        expected.delete();
        run_model(t);
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_leds(test_name, 8'h00, leds); // cleared by reset.
        c = 0;
        while (expected.size() != 0 && c < len[t] * 8) begin
            @(posedge clk);
            c++;
        end
        if (expected.size() != 0) begin
            $display("Error: test %s is missing %0d leds strobes", test_name, expected.size());
            errors++;
            expected.delete();
        end
        repeat (24) @(posedge clk); // late strobes are caught here.
    endtask

    initial begin
        int sum;
        clk    = 1'b0;
        rst    = 1'b1;
        errors = 0;
        checks = 0;
        sum    = 0;
        build_programs();
        for (int t = 0; t < $size(names); t++)
            sum += len[t];
        total_cycles = sum * 8 + $size(names) * 64;
        for (int t = 0; t < $size(names); t++)
            run_test(t);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait (total_cycles != 0);
        repeat (total_cycles) @(posedge clk);
        $display("Error: run did not complete within %0d cycles", total_cycles);
        $display("Summary: %0d checks, %0d errors", checks, errors + 1);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
hdl/rv32_pkg.sv
hdl/rv32_fetch.sv
hdl/rv32_decode.sv
hdl/rv32_execute.sv
hdl/rv32_mem.sv
hdl/rv32_hazard.sv
hdl/rv32_mem_arbiter.sv
hdl/rv32.sv
tb/rv32_checker.sv
tb/rv32_tb.sv

// File: Makefile
SRCS := $(filter-out +incdir+%,$(shell cat compile.f)) include/rv32_opcodes.svh

.PHONY: run clean

run: obj_dir/Vrv32_tb
	./obj_dir/Vrv32_tb | tee sim.log
	grep -q "Finished with no errors" sim.log

obj_dir/Vrv32_tb: compile.f $(SRCS)
	verilator --binary --timing --assert --top-module rv32_tb -f compile.f -o Vrv32_tb

clean:
	rm -rf obj_dir sim.log
